// File: src/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath widths
`define DATA_W      32
`define REG_ADDR_W  5
`define NUM_REGS    32

// decoded field widths
`define FUNCT_W     6
`define SHAMT_W     5
`define EXC_W       5

// execute latency in cycles
`define ALU_LAT     2

// reorder buffer, depth must be a power of two
`define ROB_DEPTH   8
`define ROB_ID_W    3

`endif

// File: src/inst_pkg.sv
`default_nettype none

`include "core_defs.svh"

package inst_pkg;

  // MIPS R-type funct codes handled by the ALU
  typedef enum logic [`FUNCT_W-1:0] {
    FN_SLL = 6'h00,
    FN_SRL = 6'h02,
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_XOR = 6'h26,
    FN_SLT = 6'h2A
  } funct_t;

  // zero means no exception
  typedef logic [`EXC_W-1:0] exc_t;

  // operation handed from dispatch to execute
  typedef struct packed {
    funct_t                  funct;
    logic [`SHAMT_W-1:0]     shamt;
    logic [`DATA_W-1:0]      op_a;
    logic [`DATA_W-1:0]      op_b;
    logic [`ROB_ID_W-1:0]    id;
  } alu_op_t;

endpackage

`default_nettype wire

// File: src/rob_pkg.sv
`default_nettype none

`include "core_defs.svh"

package rob_pkg;

  typedef logic [`ROB_ID_W-1:0] rob_id_t;

  typedef struct packed {
    logic                    done;
    logic                    reg_we;
    logic [`REG_ADDR_W-1:0]  reg_addr;
    logic [`DATA_W-1:0]      value;
    logic [`DATA_W-1:0]      pc;
    inst_pkg::exc_t          exc;
  } rob_entry_t;

  // record of one retired instruction
  typedef struct packed {
    logic                    reg_we;
    logic [`REG_ADDR_W-1:0]  reg_addr;
    logic [`DATA_W-1:0]      value;
    rob_id_t                 id;
    logic [`DATA_W-1:0]      pc;
    inst_pkg::exc_t          exc;
  } commit_t;

endpackage

`default_nettype wire

// File: src/core_ifs.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

// dispatch <-> reorder buffer: allocation and operand queries
interface alloc_if;
  import rob_pkg::*;

  logic               can_write;
  rob_id_t            alloc_id;
  logic               alloc_en;
  rob_entry_t         entry;
  rob_id_t            query_id_1;
  rob_id_t            query_id_2;
  logic               query_ready_1;
  logic               query_ready_2;
  logic [`DATA_W-1:0] query_data_1;
  logic [`DATA_W-1:0] query_data_2;

  modport dispatch (
    input  can_write, alloc_id, query_ready_1, query_ready_2, query_data_1, query_data_2,
    output alloc_en, entry, query_id_1, query_id_2
  );

  modport rob (
    output can_write, alloc_id, query_ready_1, query_ready_2, query_data_1, query_data_2,
    input  alloc_en, entry, query_id_1, query_id_2
  );
endinterface

// retire strobe towards the register file
interface commit_if;
  import rob_pkg::*;

  logic    valid;
  commit_t rec;

  modport rob  (output valid, rec);
  modport regs (input valid, rec);
endinterface

`default_nettype wire

// File: src/rob_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module rob_dispatch (
  alloc_if.dispatch                alloc,
  input  wire logic                reg_write_en_in,
  input  wire logic [`REG_ADDR_W-1:0] reg_write_addr_in,
  input  wire logic [`REG_ADDR_W-1:0] src_addr_1_in,
  input  wire logic [`REG_ADDR_W-1:0] src_addr_2_in,
  input  wire logic [`FUNCT_W-1:0] funct_in,
  input  wire logic [`SHAMT_W-1:0] shamt_in,
  input  inst_pkg::exc_t           exception_type_in,
  input  wire logic [`DATA_W-1:0]  pc_in,
  input  wire logic                src_busy_1,
  input  wire logic                src_busy_2,
  input  rob_pkg::rob_id_t         src_id_1,
  input  rob_pkg::rob_id_t         src_id_2,
  input  wire logic [`DATA_W-1:0]  src_data_1,
  input  wire logic [`DATA_W-1:0]  src_data_2,
  output logic                     rename_en,
  output logic [`REG_ADDR_W-1:0]   rename_addr,
  output rob_pkg::rob_id_t         rename_id,
  output logic [`REG_ADDR_W-1:0]   src_addr_1,
  output logic [`REG_ADDR_W-1:0]   src_addr_2,
  output logic                     alu_valid,
  output inst_pkg::alu_op_t        alu_op,
  output logic                     stall
);
  import inst_pkg::*;
  import rob_pkg::*;

  logic       inst_valid;
  logic       is_exc;
  logic       ready_1;
  logic       ready_2;
  logic       fire;
  rob_entry_t new_entry;

  // a real instruction writes a nonzero register or carries an exception
  assign is_exc     = |exception_type_in;
  assign inst_valid = reg_write_en_in ? |reg_write_addr_in : is_exc;

  assign src_addr_1       = src_addr_1_in;
  assign src_addr_2       = src_addr_2_in;
  assign alloc.query_id_1 = src_id_1;
  assign alloc.query_id_2 = src_id_2;

  // busy operand is usable once its producer entry is done
  assign ready_1 = !src_busy_1 || alloc.query_ready_1;
  assign ready_2 = !src_busy_2 || alloc.query_ready_2;

  assign stall = inst_valid && (!alloc.can_write || !(ready_1 && ready_2));
  assign fire  = inst_valid && !stall;

  assign alloc.alloc_en = fire;
  assign rename_en      = fire && !is_exc;
  assign rename_addr    = reg_write_addr_in;
  assign rename_id      = alloc.alloc_id;
  assign alu_valid      = fire && !is_exc;

  // exception entries skip execute and start done
  always_comb begin
    new_entry.done     = is_exc;
    new_entry.reg_we   = reg_write_en_in && !is_exc;
    new_entry.reg_addr = reg_write_addr_in;
    new_entry.value    = '0;
    new_entry.pc       = pc_in;
    new_entry.exc      = exception_type_in;
  end
  assign alloc.entry = new_entry;

  always_comb begin
    alu_op.funct = funct_t'(funct_in);
    alu_op.shamt = shamt_in;
    alu_op.op_a  = src_busy_1 ? alloc.query_data_1 : src_data_1;
    alu_op.op_b  = src_busy_2 ? alloc.query_data_2 : src_data_2;
    alu_op.id    = alloc.alloc_id;
  end

endmodule

`default_nettype wire

// File: src/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module alu_exec (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               alu_valid,
  input  inst_pkg::alu_op_t       alu_op,
  output logic                    wb_valid,
  output rob_pkg::rob_id_t        wb_id,
  output logic [`DATA_W-1:0]      wb_data
);
  import inst_pkg::*;
  import rob_pkg::*;

  logic [`DATA_W-1:0]  result;
  logic [`ALU_LAT-1:0] stage_vld;
  logic [`DATA_W-1:0]  stage_res [`ALU_LAT];
  rob_id_t             stage_id  [`ALU_LAT];

  always_comb begin
    case (alu_op.funct)
      FN_ADD:  result = alu_op.op_a + alu_op.op_b;
      FN_SUB:  result = alu_op.op_a - alu_op.op_b;
      FN_AND:  result = alu_op.op_a & alu_op.op_b;
      FN_OR:   result = alu_op.op_a | alu_op.op_b;
      FN_XOR:  result = alu_op.op_a ^ alu_op.op_b;
      FN_SLL:  result = alu_op.op_b << alu_op.shamt;
      FN_SRL:  result = alu_op.op_b >> alu_op.shamt;
      FN_SLT:  result = {{(`DATA_W-1){1'b0}}, $signed(alu_op.op_a) < $signed(alu_op.op_b)};
      default: result = '0;
    endcase
  end

  // valid bits travel with the data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_vld <= '0;
    end else begin
      stage_vld <= {stage_vld[`ALU_LAT-2:0], alu_valid};
    end
  end

  always_ff @(posedge clk) begin
    stage_res[0] <= result;
    stage_id[0]  <= alu_op.id;
    for (int i = 1; i < `ALU_LAT; i++) begin
      stage_res[i] <= stage_res[i-1];
      stage_id[i]  <= stage_id[i-1];
    end
  end

  assign wb_valid = stage_vld[`ALU_LAT-1];
  assign wb_id    = stage_id[`ALU_LAT-1];
  assign wb_data  = stage_res[`ALU_LAT-1];

endmodule

`default_nettype wire

// File: src/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module reorder_buffer (
  input  wire logic               clk,
  input  wire logic               rst_n,
  alloc_if.rob                    alloc,
  input  wire logic               wb_valid,
  input  rob_pkg::rob_id_t        wb_id,
  input  wire logic [`DATA_W-1:0] wb_data,
  commit_if.rob                   commit
);
  import rob_pkg::*;

  rob_entry_t          entries [`ROB_DEPTH];
  rob_id_t             head;
  rob_id_t             tail;
  logic [`ROB_ID_W:0]  count;
  logic                do_alloc;
  logic                retire;

  assign alloc.can_write = (count != `ROB_DEPTH);
  assign alloc.alloc_id  = tail;
  assign do_alloc        = alloc.alloc_en && alloc.can_write;

  // head leaves once its result is in
  assign retire = (count != 0) && entries[head].done;

  // operand forwarding by producer id
  assign alloc.query_ready_1 = entries[alloc.query_id_1].done;
  assign alloc.query_ready_2 = entries[alloc.query_id_2].done;
  assign alloc.query_data_1  = entries[alloc.query_id_1].value;
  assign alloc.query_data_2  = entries[alloc.query_id_2].value;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      commit.valid <= 1'b0;
    end else begin
      commit.valid <= retire;
      if (do_alloc) begin
        tail <= tail + 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
      case ({do_alloc, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // tail slot is free, so it never collides with a writeback
  always_ff @(posedge clk) begin
    if (do_alloc) begin
      entries[tail] <= alloc.entry;
    end
    if (wb_valid) begin
      entries[wb_id].done  <= 1'b1;
      entries[wb_id].value <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (retire) begin
      commit.rec.reg_we   <= entries[head].reg_we;
      commit.rec.reg_addr <= entries[head].reg_addr;
      commit.rec.value    <= entries[head].value;
      commit.rec.id       <= head;
      commit.rec.pc       <= entries[head].pc;
      commit.rec.exc      <= entries[head].exc;
    end
  end

endmodule

`default_nettype wire

// File: src/reg_status.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module reg_status (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   rename_en,
  input  wire logic [`REG_ADDR_W-1:0] rename_addr,
  input  rob_pkg::rob_id_t            rename_id,
  input  wire logic [`REG_ADDR_W-1:0] src_addr_1,
  input  wire logic [`REG_ADDR_W-1:0] src_addr_2,
  commit_if.regs                      commit,
  output logic                        src_busy_1,
  output logic                        src_busy_2,
  output rob_pkg::rob_id_t            src_id_1,
  output rob_pkg::rob_id_t            src_id_2,
  output logic [`DATA_W-1:0]          src_data_1,
  output logic [`DATA_W-1:0]          src_data_2
);
  import rob_pkg::*;

  logic [`DATA_W-1:0]   regs [`NUM_REGS];
  logic [`NUM_REGS-1:0] busy;
  rob_id_t              owner [`NUM_REGS];
  logic                 wr_en;

  assign wr_en = commit.valid && commit.rec.reg_we && (commit.rec.reg_addr != '0);

  // rename after commit, so a same-cycle rename keeps the register busy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= '0;
    end else begin
      if (wr_en && (owner[commit.rec.reg_addr] == commit.rec.id)) begin
        busy[commit.rec.reg_addr] <= 1'b0;
      end
      if (rename_en && (rename_addr != '0)) begin
        busy[rename_addr] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[commit.rec.reg_addr] <= commit.rec.value;
    end
    if (rename_en) begin
      owner[rename_addr] <= rename_id;
    end
  end

  // r0 reads zero and is never busy
  assign src_busy_1 = (src_addr_1 != '0) && busy[src_addr_1];
  assign src_busy_2 = (src_addr_2 != '0) && busy[src_addr_2];
  assign src_id_1   = owner[src_addr_1];
  assign src_id_2   = owner[src_addr_2];
  assign src_data_1 = (src_addr_1 == '0) ? '0 : regs[src_addr_1];
  assign src_data_2 = (src_addr_2 == '0) ? '0 : regs[src_addr_2];

endmodule

`default_nettype wire

// File: src/ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module ooo_core_top (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   reg_write_en_in,
  input  wire logic [`REG_ADDR_W-1:0] reg_write_addr_in,
  input  wire logic [`REG_ADDR_W-1:0] src_addr_1_in,
  input  wire logic [`REG_ADDR_W-1:0] src_addr_2_in,
  input  wire logic [`FUNCT_W-1:0]    funct_in,
  input  wire logic [`SHAMT_W-1:0]    shamt_in,
  input  wire logic [`EXC_W-1:0]      exception_type_in,
  input  wire logic [`DATA_W-1:0]     pc_in,
  output logic                        stall,
  output logic                        commit_valid,
  output logic                        commit_reg_write_en,
  output logic [`REG_ADDR_W-1:0]      commit_reg_addr,
  output logic [`DATA_W-1:0]          commit_data,
  output logic [`DATA_W-1:0]          commit_pc,
  output logic [`EXC_W-1:0]           commit_exception
);
  import inst_pkg::*;
  import rob_pkg::*;

  alloc_if  alloc_bus ();
  commit_if commit_bus ();

  logic                   src_busy_1;
  logic                   src_busy_2;
  rob_id_t                src_id_1;
  rob_id_t                src_id_2;
  logic [`DATA_W-1:0]     src_data_1;
  logic [`DATA_W-1:0]     src_data_2;
  logic [`REG_ADDR_W-1:0] src_addr_1;
  logic [`REG_ADDR_W-1:0] src_addr_2;
  logic                   rename_en;
  logic [`REG_ADDR_W-1:0] rename_addr;
  rob_id_t                rename_id;
  logic                   alu_valid;
  alu_op_t                alu_op;
  logic                   wb_valid;
  rob_id_t                wb_id;
  logic [`DATA_W-1:0]     wb_data;

  rob_dispatch rob_dispatch_inst (
    .alloc             (alloc_bus.dispatch),
    .reg_write_en_in   (reg_write_en_in),
    .reg_write_addr_in (reg_write_addr_in),
    .src_addr_1_in     (src_addr_1_in),
    .src_addr_2_in     (src_addr_2_in),
    .funct_in          (funct_in),
    .shamt_in          (shamt_in),
    .exception_type_in (exception_type_in),
    .pc_in             (pc_in),
    .src_busy_1        (src_busy_1),
    .src_busy_2        (src_busy_2),
    .src_id_1          (src_id_1),
    .src_id_2          (src_id_2),
    .src_data_1        (src_data_1),
    .src_data_2        (src_data_2),
    .rename_en         (rename_en),
    .rename_addr       (rename_addr),
    .rename_id         (rename_id),
    .src_addr_1        (src_addr_1),
    .src_addr_2        (src_addr_2),
    .alu_valid         (alu_valid),
    .alu_op            (alu_op),
    .stall             (stall)
  );

  alu_exec alu_exec_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .alu_valid (alu_valid),
    .alu_op    (alu_op),
    .wb_valid  (wb_valid),
    .wb_id     (wb_id),
    .wb_data   (wb_data)
  );

  reorder_buffer reorder_buffer_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .alloc    (alloc_bus.rob),
    .wb_valid (wb_valid),
    .wb_id    (wb_id),
    .wb_data  (wb_data),
    .commit   (commit_bus.rob)
  );

  reg_status reg_status_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .rename_en   (rename_en),
    .rename_addr (rename_addr),
    .rename_id   (rename_id),
    .src_addr_1  (src_addr_1),
    .src_addr_2  (src_addr_2),
    .commit      (commit_bus.regs),
    .src_busy_1  (src_busy_1),
    .src_busy_2  (src_busy_2),
    .src_id_1    (src_id_1),
    .src_id_2    (src_id_2),
    .src_data_1  (src_data_1),
    .src_data_2  (src_data_2)
  );

  // retire record out to the ports
  assign commit_valid        = commit_bus.valid;
  assign commit_reg_write_en = commit_bus.rec.reg_we;
  assign commit_reg_addr     = commit_bus.rec.reg_addr;
  assign commit_data         = commit_bus.rec.value;
  assign commit_pc           = commit_bus.rec.pc;
  assign commit_exception    = commit_bus.rec.exc;

endmodule

`default_nettype wire

// File: bench/ooo_core_tb_table.svh
localparam int NUM_ROWS = 31;

logic [26:0] table_rows [NUM_ROWS];

// columns: write enable, rd, rs1, rs2, funct, exception code
task automatic load_table();
  // seed registers from r0
  table_rows[0]  = {1'b1, 5'd1,  5'd0,  5'd0,  6'h20, 5'd0};
  table_rows[1]  = {1'b1, 5'd2,  5'd0,  5'd0,  6'h20, 5'd0};
  table_rows[2]  = {1'b1, 5'd3,  5'd0,  5'd0,  6'h20, 5'd0};
  table_rows[3]  = {1'b1, 5'd4,  5'd0,  5'd0,  6'h20, 5'd0};
  // one of each funct, each reading the previous result
  table_rows[4]  = {1'b1, 5'd5,  5'd1,  5'd2,  6'h22, 5'd0};
  table_rows[5]  = {1'b1, 5'd6,  5'd5,  5'd3,  6'h24, 5'd0};
  table_rows[6]  = {1'b1, 5'd7,  5'd6,  5'd4,  6'h25, 5'd0};
  table_rows[7]  = {1'b1, 5'd8,  5'd7,  5'd1,  6'h26, 5'd0};
  table_rows[8]  = {1'b1, 5'd9,  5'd0,  5'd8,  6'h00, 5'd0};
  table_rows[9]  = {1'b1, 5'd10, 5'd0,  5'd9,  6'h02, 5'd0};
  table_rows[10] = {1'b1, 5'd11, 5'd5,  5'd1,  6'h2A, 5'd0};
  // bubbles
  table_rows[11] = {1'b1, 5'd0,  5'd1,  5'd2,  6'h20, 5'd0};
  table_rows[12] = {1'b0, 5'd3,  5'd1,  5'd2,  6'h20, 5'd0};
  table_rows[13] = {1'b1, 5'd12, 5'd0,  5'd0,  6'h20, 5'd0};
  // exceptions, the second one names r12 as its target
  table_rows[14] = {1'b0, 5'd0,  5'd0,  5'd0,  6'h00, 5'd4};
  table_rows[15] = {1'b1, 5'd12, 5'd1,  5'd2,  6'h22, 5'd10};
  // write to r0 with an exception is still a bubble
  table_rows[16] = {1'b1, 5'd0,  5'd0,  5'd0,  6'h00, 5'd3};
  table_rows[17] = {1'b1, 5'd13, 5'd12, 5'd11, 6'h20, 5'd0};
  table_rows[18] = {1'b1, 5'd14, 5'd1,  5'd2,  6'h3F, 5'd0};
  // back to back dependent chain
  table_rows[19] = {1'b1, 5'd1,  5'd1,  5'd1,  6'h20, 5'd0};
  table_rows[20] = {1'b1, 5'd1,  5'd1,  5'd1,  6'h22, 5'd0};
  table_rows[21] = {1'b1, 5'd2,  5'd1,  5'd1,  6'h2A, 5'd0};
  // independent burst longer than the buffer
  for (int i = 0; i < 9; i++) begin
    table_rows[22 + i] = {1'b1, 5'(15 + i), 5'd0, 5'd0, 6'h20, 5'd0};
  end
endtask

// File: bench/ooo_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module ooo_core_tb;

  typedef struct packed {
    logic [26:0] row;
    logic [4:0]  shamt;
    logic [31:0] pc;
  } item_t;

  typedef struct packed {
    logic        we;
    logic [4:0]  addr;
    logic [31:0] data;
    logic [31:0] pc;
    logic [4:0]  exc;
  } commit_rec_t;

  logic                   clk;
  logic                   rst_n;
  logic                   reg_write_en_in;
  logic [`REG_ADDR_W-1:0] reg_write_addr_in;
  logic [`REG_ADDR_W-1:0] src_addr_1_in;
  logic [`REG_ADDR_W-1:0] src_addr_2_in;
  logic [`FUNCT_W-1:0]    funct_in;
  logic [`SHAMT_W-1:0]    shamt_in;
  logic [`EXC_W-1:0]      exception_type_in;
  logic [`DATA_W-1:0]     pc_in;
  logic                   stall;
  logic                   commit_valid;
  logic                   commit_reg_write_en;
  logic [`REG_ADDR_W-1:0] commit_reg_addr;
  logic [`DATA_W-1:0]     commit_data;
  logic [`DATA_W-1:0]     commit_pc;
  logic [`EXC_W-1:0]      commit_exception;

  item_t       stream [$];
  commit_rec_t expected [$];
  commit_rec_t exp_rec;
  logic [31:0] gold_regs [`NUM_REGS];
  logic [23:0] lfsr_state;
  int          mismatches;
  int          failures;
  int          commits;
  int          n_expected;
  int          cycles;
  int          cycle_limit;
  int          idx;

  `include "ooo_core_tb_table.svh"

  ooo_core_top ooo_core_top_inst (
    .clk                 (clk),
    .rst_n               (rst_n),
    .reg_write_en_in     (reg_write_en_in),
    .reg_write_addr_in   (reg_write_addr_in),
    .src_addr_1_in       (src_addr_1_in),
    .src_addr_2_in       (src_addr_2_in),
    .funct_in            (funct_in),
    .shamt_in            (shamt_in),
    .exception_type_in   (exception_type_in),
    .pc_in               (pc_in),
    .stall               (stall),
    .commit_valid        (commit_valid),
    .commit_reg_write_en (commit_reg_write_en),
    .commit_reg_addr     (commit_reg_addr),
    .commit_data         (commit_data),
    .commit_pc           (commit_pc),
    .commit_exception    (commit_exception)
  );

  always #5 clk = ~clk;

  // fibonacci, taps 24 23 22 17
  function automatic logic [23:0] lfsr_next(input logic [23:0] s);
    return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
  endfunction

  task automatic take_bits(input int n, output logic [4:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[3:0], lfsr_state[0]};
    end
  endtask

  // reference ALU from the MIPS funct definitions
  function automatic logic [31:0] alu_model(input logic [5:0] funct, input logic [4:0] shamt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (funct)
      6'h20:   return a + b;
      6'h22:   return a - b;
      6'h24:   return a & b;
      6'h25:   return a | b;
      6'h26:   return a ^ b;
      6'h00:   return b << shamt;
      6'h02:   return b >> shamt;
      6'h2A:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return '0;
    endcase
  endfunction

  // program order stream plus expected commits from the golden registers
  task automatic build_stream();
    item_t       it;
    commit_rec_t rec;
    logic [4:0]  bits;
    logic        valid;
    for (int i = 0; i < NUM_ROWS; i++) begin
      take_bits(2, bits);
      if (bits[1:0] == 2'b11) begin
        it = '0;
        it.pc = 32'h1000 + 4 * stream.size();
        stream.push_back(it);
      end
      take_bits(5, bits);
      it.row   = table_rows[i];
      it.shamt = bits;
      it.pc    = 32'h1000 + 4 * stream.size();
      stream.push_back(it);
      valid = it.row[26] ? (it.row[25:21] != 0) : (it.row[4:0] != 0);
      if (valid) begin
        // exceptions never write a register
        rec.we   = (it.row[4:0] == 0);
        rec.addr = it.row[25:21];
        rec.pc   = it.pc;
        rec.exc  = it.row[4:0];
        rec.data = alu_model(it.row[10:5], it.shamt, gold_regs[it.row[20:16]],
                             gold_regs[it.row[15:11]]);
        if (rec.we) begin
          gold_regs[rec.addr] = rec.data;
        end
        expected.push_back(rec);
      end
    end
  endtask

  task automatic apply_item(input item_t it);
    reg_write_en_in   <= it.row[26];
    reg_write_addr_in <= it.row[25:21];
    src_addr_1_in     <= it.row[20:16];
    src_addr_2_in     <= it.row[15:11];
    funct_in          <= it.row[10:5];
    shamt_in          <= it.shamt;
    exception_type_in <= it.row[4:0];
    pc_in             <= it.pc;
  endtask

  task automatic compare_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    assert (act === exp) else begin
      mismatches++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && commit_valid) begin
      commits++;
      assert (expected.size() != 0) else begin
        failures++;
        $display("Extra commit at %0t with pc %h beyond the valid rows", $time, commit_pc);
      end
      if (expected.size() != 0) begin
        exp_rec = expected.pop_front();
        compare_field("commit_reg_write_en", exp_rec.we, commit_reg_write_en);
        compare_field("commit_pc", exp_rec.pc, commit_pc);
        compare_field("commit_exception", exp_rec.exc, commit_exception);
        if (exp_rec.we) begin
          compare_field("commit_reg_addr", exp_rec.addr, commit_reg_addr);
          compare_field("commit_data", exp_rec.data, commit_data);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles with %0d commits still missing",
               cycles, expected.size());
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rst_n <= 1'b0;
    apply_item('0);
    mismatches = 0;
    failures = 0;
    commits = 0;
    cycles = 0;
    lfsr_state = 24'd93364;
    foreach (gold_regs[i]) begin
      gold_regs[i] = '0;
    end
    load_table();
    build_stream();
    n_expected = expected.size();
    cycle_limit = 8 * stream.size() + 100;

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (commit_valid === 1'b0 && stall === 1'b0) else begin
      failures++;
      $display("commit_valid or stall not low after reset at %0t", $time);
    end

    // hold each item while stall is high
    apply_item(stream[0]);
    idx = 0;
    while (idx < stream.size()) begin
      @(posedge clk);
      if (!stall) begin
        idx++;
        if (idx < stream.size()) begin
          apply_item(stream[idx]);
        end else begin
          apply_item('0);
        end
      end
    end

    while (expected.size() != 0) @(posedge clk);
    repeat (10) @(posedge clk);
    assert (commits == n_expected) else begin
      failures++;
      $display("Saw %0d commits but %0d rows were valid", commits, n_expected);
    end

    $display("errors: %0d mismatches, %0d other failures, %0d of %0d commits seen",
             mismatches, failures, commits, n_expected);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+src
+incdir+bench
src/inst_pkg.sv
src/rob_pkg.sv
src/core_ifs.sv
src/rob_dispatch.sv
src/alu_exec.sv
src/reorder_buffer.sv
src/reg_status.sv
src/ooo_core_top.sv
bench/ooo_core_tb.sv
